//--- src/mmio_pkg.sv
/*
 * Address map, bus structs and enums shared by the MMIO register block.
 * RTL files reach these through mmio_pkg:: scoped names.
 */
`default_nettype none

package mmio_pkg;

   // ========================================================================
   // Address map
   // ========================================================================
   localparam int ACTION_BIT = 31;          // 1 = action space, 0 = shell space
   localparam int BASE_HI    = 21;          // Shell register group
   localparam int BASE_LO    = 8;
   localparam int OFFS_HI    = 7;           // Register within the group
   localparam int OFFS_LO    = 0;

   localparam logic [13:0] BASE_CORE  = 14'h0000;
   localparam logic [13:0] BASE_DEBUG = 14'h01A0;
   localparam logic [13:0] BASE_FIR   = 14'h01C0;

   // Core group
   localparam logic [7:0] OFF_IVR       = 8'h00;  // RO
   localparam logic [7:0] OFF_SCR       = 8'h10;  // WO
   localparam logic [7:0] OFF_SSR       = 8'h18;  // RO
   localparam logic [7:0] OFF_CAP       = 8'h30;  // RO
   localparam logic [7:0] OFF_FRT       = 8'h40;  // RO

   // Debug group
   localparam logic [7:0] OFF_DBG_CLR   = 8'h00;  // WO, one-cycle clear
   localparam logic [7:0] OFF_TLX_CMD   = 8'h08;
   localparam logic [7:0] OFF_TLX_RSP   = 8'h10;
   localparam logic [7:0] OFF_AXI_CMD   = 8'h40;
   localparam logic [7:0] OFF_AXI_RSP   = 8'h48;
   localparam logic [7:0] OFF_BUF_CNT   = 8'h50;
   localparam logic [7:0] OFF_TLX_LIM   = 8'h60;  // RW
   localparam logic [7:0] OFF_AXI_LIM   = 8'h68;  // RW

   // Fault isolation group
   localparam logic [7:0] OFF_FIFO_OVFL = 8'h00;
   localparam logic [7:0] OFF_TLX_INTF  = 8'h08;

   // ========================================================================
   // Bus structs
   // ========================================================================
   typedef struct packed {
      logic        wr;
      logic        rd;
      logic        dw;                      // 1 = 64-bit access
      logic [31:0] addr;
      logic [63:0] din;
   } mmio_req_t;

   typedef struct packed {
      logic [63:0] dout;
      logic        done;
      logic        failed;
   } mmio_rsp_t;

   typedef struct packed {
      logic        wr;                      // One-cycle strobes
      logic        rd;
      logic [31:0] addr;
      logic [31:0] din;
   } lcl_req_t;

   typedef struct packed {
      logic        ack;                     // Write answer
      logic        rsp;                     // 1 = good
      logic [31:0] dout;
      logic        dv;                      // Read answer
   } lcl_rsp_t;

   typedef struct packed {
      logic [63:0] tlx_cmd;
      logic [63:0] tlx_rsp;
      logic [63:0] axi_cmd;
      logic [63:0] axi_rsp;
      logic [63:0] buf_cnt;
   } debug_cnt_t;

   typedef struct packed {
      logic [63:0] fifo_ovfl;
      logic [63:0] tlx_intf;
   } fir_t;

   // ========================================================================
   // Enums
   // ========================================================================
   typedef enum logic [2:0] {
      ACC_NONE, ACC_SHELL_WR, ACC_SHELL_RD, ACC_ACTION, ACC_BAD_WIDTH
   } access_e;

   typedef enum logic [3:0] {
      SEL_NONE, SEL_IVR, SEL_SCR, SEL_SSR, SEL_CAP, SEL_FRT,
      SEL_DBG_CLR, SEL_TLX_CMD, SEL_TLX_RSP, SEL_AXI_CMD, SEL_AXI_RSP,
      SEL_BUF_CNT, SEL_TLX_LIM, SEL_AXI_LIM, SEL_FIFO_OVFL, SEL_TLX_INTF
   } reg_sel_e;

endpackage

`default_nettype wire

//--- src/mmio_access_decode.sv
/*
 * Classifies each host request and decodes the shell register target.
 * Results are registered, so they are valid the cycle after the request.
 */
`timescale 1ns/10ps
`default_nettype none

module mmio_access_decode (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire mmio_pkg::mmio_req_t mmio_req,
   output mmio_pkg::access_e        access,
   output mmio_pkg::reg_sel_e       reg_sel,
   output logic [63:0]              wdata,
   output logic                     action_start
);

   mmio_pkg::access_e  req_kind;
   mmio_pkg::reg_sel_e req_sel;

   // Map group, offset and direction to a register, SEL_NONE if not allowed
   function automatic mmio_pkg::reg_sel_e decode_sel(input logic [13:0] base,
                                                     input logic [7:0]  offs,
                                                     input logic        is_wr);
      mmio_pkg::reg_sel_e sel;
      sel = mmio_pkg::SEL_NONE;
      case (base)
         mmio_pkg::BASE_CORE:
            case (offs)
               mmio_pkg::OFF_IVR : if (!is_wr) sel = mmio_pkg::SEL_IVR;
               mmio_pkg::OFF_SCR : if (is_wr)  sel = mmio_pkg::SEL_SCR;
               mmio_pkg::OFF_SSR : if (!is_wr) sel = mmio_pkg::SEL_SSR;
               mmio_pkg::OFF_CAP : if (!is_wr) sel = mmio_pkg::SEL_CAP;
               mmio_pkg::OFF_FRT : if (!is_wr) sel = mmio_pkg::SEL_FRT;
               default           : sel = mmio_pkg::SEL_NONE;
            endcase
         mmio_pkg::BASE_DEBUG:
            case (offs)
               mmio_pkg::OFF_DBG_CLR : if (is_wr)  sel = mmio_pkg::SEL_DBG_CLR;
               mmio_pkg::OFF_TLX_CMD : if (!is_wr) sel = mmio_pkg::SEL_TLX_CMD;
               mmio_pkg::OFF_TLX_RSP : if (!is_wr) sel = mmio_pkg::SEL_TLX_RSP;
               mmio_pkg::OFF_AXI_CMD : if (!is_wr) sel = mmio_pkg::SEL_AXI_CMD;
               mmio_pkg::OFF_AXI_RSP : if (!is_wr) sel = mmio_pkg::SEL_AXI_RSP;
               mmio_pkg::OFF_BUF_CNT : if (!is_wr) sel = mmio_pkg::SEL_BUF_CNT;
               mmio_pkg::OFF_TLX_LIM : sel = mmio_pkg::SEL_TLX_LIM;    // RW
               mmio_pkg::OFF_AXI_LIM : sel = mmio_pkg::SEL_AXI_LIM;    // RW
               default               : sel = mmio_pkg::SEL_NONE;
            endcase
         mmio_pkg::BASE_FIR:
            case (offs)
               mmio_pkg::OFF_FIFO_OVFL : if (!is_wr) sel = mmio_pkg::SEL_FIFO_OVFL;
               mmio_pkg::OFF_TLX_INTF  : if (!is_wr) sel = mmio_pkg::SEL_TLX_INTF;
               default                 : sel = mmio_pkg::SEL_NONE;
            endcase
         default: sel = mmio_pkg::SEL_NONE;            // Unmapped group
      endcase
      return sel;
   endfunction

   // Shell wants 64-bit, action wants 32-bit
   always_comb
   begin
      req_kind = mmio_pkg::ACC_NONE;
      req_sel  = mmio_pkg::SEL_NONE;
      if (mmio_req.wr || mmio_req.rd)
      begin
         if (mmio_req.addr[mmio_pkg::ACTION_BIT] == mmio_req.dw)
            req_kind = mmio_pkg::ACC_BAD_WIDTH;
         else if (mmio_req.addr[mmio_pkg::ACTION_BIT])
            req_kind = mmio_pkg::ACC_ACTION;
         else
         begin
            req_kind = mmio_req.wr ? mmio_pkg::ACC_SHELL_WR : mmio_pkg::ACC_SHELL_RD;
            req_sel  = decode_sel(mmio_req.addr[mmio_pkg::BASE_HI:mmio_pkg::BASE_LO],
                                  mmio_req.addr[mmio_pkg::OFFS_HI:mmio_pkg::OFFS_LO],
                                  mmio_req.wr);
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         access  <= mmio_pkg::ACC_NONE;
         reg_sel <= mmio_pkg::SEL_NONE;
      end
      else
      begin
         access  <= req_kind;                          // Held for one cycle only
         reg_sel <= req_sel;
      end
   end

   always_ff @(posedge clk)
   begin
      if (mmio_req.wr)
         wdata <= mmio_req.din;                        // Write payload
   end

   assign action_start = (access == mmio_pkg::ACC_ACTION);   // Valid action access only

endmodule

`default_nettype wire

//--- src/shell_regs.sv
/*
 * Shell register file. Takes the decoded access, performs the write or
 * read and returns a one-cycle result, plus status and debug controls.
 */
`timescale 1ns/10ps
`default_nettype none

module shell_regs #(
   parameter logic [63:0] IMP_VERSION = 64'h0,
   parameter logic [63:0] CAPABILITY  = 64'h0
) (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire mmio_pkg::access_e    access,
   input  wire mmio_pkg::reg_sel_e   reg_sel,
   input  wire logic [63:0]          wdata,
   input  wire mmio_pkg::debug_cnt_t debug_cnt,
   input  wire mmio_pkg::fir_t       fir,
   output logic                      result_valid,
   output logic                      result_failed,
   output logic [63:0]               result_data,
   output logic                      cmd_strobe,       // Soft reset request
   output logic                      debug_cnt_clear,
   output logic [63:0]               tlx_idle_lim,
   output logic [63:0]               axi_idle_lim
);

   logic [63:0]          frt;                          // Free-running counter
   logic [3:0]           status;                       // fatal, axi busy, tlx busy, idle
   mmio_pkg::debug_cnt_t cnt_snap;
   mmio_pkg::fir_t       fir_snap;
   logic [63:0]          rdata;
   logic                 shell_wr;
   logic                 shell_rd;

   assign shell_wr = (access == mmio_pkg::ACC_SHELL_WR);
   assign shell_rd = (access == mmio_pkg::ACC_SHELL_RD);

   // ========================================================================
   // Snapshots, status and free-running time
   // ========================================================================
   always_ff @(posedge clk)
   begin
      cnt_snap <= debug_cnt;
      fir_snap <= fir;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         status <= '0;
         frt    <= '0;
      end
      else
      begin
         status[0] <= (debug_cnt.buf_cnt == 64'd0);            // Buffers empty
         status[1] <= (debug_cnt.tlx_cmd != debug_cnt.tlx_rsp);
         status[2] <= (debug_cnt.axi_cmd != debug_cnt.axi_rsp);
         status[3] <= |{fir.fifo_ovfl, fir.tlx_intf};          // Any fault bit
         frt       <= frt + 64'd1;
      end
   end

   // ========================================================================
   // Writes
   // ========================================================================
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cmd_strobe      <= 1'b0;
         debug_cnt_clear <= 1'b0;
         tlx_idle_lim    <= '0;
         axi_idle_lim    <= '0;
      end
      else
      begin
         // Self-clearing, high for one cycle per write
         cmd_strobe      <= shell_wr && (reg_sel == mmio_pkg::SEL_SCR) && wdata[0];
         debug_cnt_clear <= shell_wr && (reg_sel == mmio_pkg::SEL_DBG_CLR) && wdata[0];
         if (shell_wr && (reg_sel == mmio_pkg::SEL_TLX_LIM))
            tlx_idle_lim <= wdata;
         if (shell_wr && (reg_sel == mmio_pkg::SEL_AXI_LIM))
            axi_idle_lim <= wdata;
      end
   end

   // ========================================================================
   // Read mux and result
   // ========================================================================
   always_comb
   begin
      case (reg_sel)
         mmio_pkg::SEL_IVR       : rdata = IMP_VERSION;
         mmio_pkg::SEL_SSR       : rdata = {60'd0, status};
         mmio_pkg::SEL_CAP       : rdata = CAPABILITY;
         mmio_pkg::SEL_FRT       : rdata = frt;
         mmio_pkg::SEL_TLX_CMD   : rdata = cnt_snap.tlx_cmd;
         mmio_pkg::SEL_TLX_RSP   : rdata = cnt_snap.tlx_rsp;
         mmio_pkg::SEL_AXI_CMD   : rdata = cnt_snap.axi_cmd;
         mmio_pkg::SEL_AXI_RSP   : rdata = cnt_snap.axi_rsp;
         mmio_pkg::SEL_BUF_CNT   : rdata = cnt_snap.buf_cnt;
         mmio_pkg::SEL_TLX_LIM   : rdata = tlx_idle_lim;
         mmio_pkg::SEL_AXI_LIM   : rdata = axi_idle_lim;
         mmio_pkg::SEL_FIFO_OVFL : rdata = fir_snap.fifo_ovfl;
         mmio_pkg::SEL_TLX_INTF  : rdata = fir_snap.tlx_intf;
         default                 : rdata = '0;         // Write-only or none
      endcase
   end

   assign result_data   = shell_rd ? rdata : 64'd0;
   assign result_valid  = (shell_wr || shell_rd) && (reg_sel != mmio_pkg::SEL_NONE);
   assign result_failed = (access == mmio_pkg::ACC_BAD_WIDTH) ||
                          ((shell_wr || shell_rd) && (reg_sel == mmio_pkg::SEL_NONE));

endmodule

`default_nettype wire

//--- src/soft_reset_gen.sv
/*
 * Stretches a command strobe into a soft-reset pulse of SOFT_RESET_CYCLES
 * for both shell and action. Strobes during a pulse are dropped.
 */
`timescale 1ns/10ps
`default_nettype none

module soft_reset_gen #(
   parameter int SOFT_RESET_CYCLES = 16
) (
   input  wire logic clk,
   input  wire logic rst_n,
   input  wire logic cmd_strobe,
   output logic      soft_reset_shell,
   output logic      soft_reset_action
);

   localparam int CNT_W = (SOFT_RESET_CYCLES > 1) ? $clog2(SOFT_RESET_CYCLES) : 1;

   typedef enum logic {ST_IDLE, ST_ACTIVE} state_e;

   state_e             state;
   logic [CNT_W-1:0]   len_cnt;                        // Cycles already in pulse

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state   <= ST_IDLE;
         len_cnt <= '0;
      end
      else if (state == ST_IDLE)
      begin
         len_cnt <= '0;
         if (cmd_strobe)
            state <= ST_ACTIVE;
      end
      else if (len_cnt == CNT_W'(SOFT_RESET_CYCLES - 1))
         state <= ST_IDLE;                             // Last pulse cycle
      else
         len_cnt <= len_cnt + 1'b1;
   end

   // Both domains share one pulse
   assign soft_reset_shell  = (state == ST_ACTIVE);
   assign soft_reset_action = (state == ST_ACTIVE);

endmodule

`default_nettype wire

//--- src/action_bridge.sv
/*
 * Forwards 32-bit action accesses to the action register bus and waits
 * for ack or dv. The answer comes back as a one-cycle result.
 */
`timescale 1ns/10ps
`default_nettype none

module action_bridge (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire logic                action_start,
   input  wire mmio_pkg::mmio_req_t mmio_req,
   output mmio_pkg::lcl_req_t       lcl_req,
   input  wire mmio_pkg::lcl_rsp_t  lcl_rsp,
   output logic                     result_valid,
   output logic                     result_failed,
   output logic [63:0]              result_data
);

   typedef enum logic {ST_IDLE, ST_WAIT_RSP} state_e;

   state_e state;
   logic   is_wr;                                      // Direction of current request
   logic   rsp_seen;

   assign rsp_seen = (state == ST_WAIT_RSP) && (lcl_rsp.ack || lcl_rsp.dv);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         is_wr <= 1'b0;
      else if (mmio_req.wr || mmio_req.rd)
         is_wr <= mmio_req.wr;                         // Captured in the request cycle
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state <= ST_IDLE;
      else
         case (state)
            ST_IDLE     : if (action_start) state <= ST_WAIT_RSP;
            ST_WAIT_RSP : if (rsp_seen)     state <= ST_IDLE;
            default     : state <= ST_IDLE;
         endcase
   end

   // ========================================================================
   // Action request, strobes last one cycle
   // ========================================================================
   always_comb
   begin
      lcl_req.wr   = action_start && (state == ST_IDLE) && is_wr;
      lcl_req.rd   = action_start && (state == ST_IDLE) && !is_wr;
      lcl_req.addr = {1'b0, mmio_req.addr[30:0]};     // Drop the space select bit
      lcl_req.din  = mmio_req.addr[2] ? mmio_req.din[63:32] : mmio_req.din[31:0];
   end

   // ========================================================================
   // Response, read data goes to the half picked by addr bit 2
   // ========================================================================
   always_comb
   begin
      result_valid  = rsp_seen && lcl_rsp.rsp;
      result_failed = rsp_seen && !lcl_rsp.rsp;
      result_data   = 64'd0;
      if (lcl_rsp.dv)
      begin
         if (mmio_req.addr[2])
            result_data = {lcl_rsp.dout, 32'd0};
         else
            result_data = {32'd0, lcl_rsp.dout};
      end
   end

endmodule

`default_nettype wire

//--- src/mmio_top.sv
/*
 * Top of the MMIO register block. Ties decode, shell registers, soft reset
 * and action bridge together and registers the merged host response.
 */
`timescale 1ns/10ps
`default_nettype none

module mmio_top #(
   parameter logic [63:0] IMP_VERSION       = 64'h0,
   parameter logic [63:0] CAPABILITY        = 64'h0,
   parameter int          SOFT_RESET_CYCLES = 16
) (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire mmio_pkg::mmio_req_t  mmio_req,
   output mmio_pkg::mmio_rsp_t       mmio_rsp,
   output mmio_pkg::lcl_req_t        lcl_req,
   input  wire mmio_pkg::lcl_rsp_t   lcl_rsp,
   input  wire mmio_pkg::debug_cnt_t debug_cnt,
   input  wire mmio_pkg::fir_t       fir,
   output logic                      debug_cnt_clear,
   output logic                      soft_reset_shell,
   output logic                      soft_reset_action,
   output logic [63:0]               tlx_idle_lim,
   output logic [63:0]               axi_idle_lim
);

   mmio_pkg::access_e  access;
   mmio_pkg::reg_sel_e reg_sel;
   logic [63:0]        wdata;
   logic               action_start;
   logic               cmd_strobe;
   logic               sh_valid, sh_failed, br_valid, br_failed;
   logic [63:0]        sh_data, br_data;
   logic               rsp_done, rsp_failed;
   logic [63:0]        rsp_dout;

   mmio_access_decode u_decode (
      .clk(clk), .rst_n(rst_n), .mmio_req(mmio_req), .access(access),
      .reg_sel(reg_sel), .wdata(wdata), .action_start(action_start));

   shell_regs #(.IMP_VERSION(IMP_VERSION), .CAPABILITY(CAPABILITY)) u_shell_regs (
      .clk(clk), .rst_n(rst_n), .access(access), .reg_sel(reg_sel), .wdata(wdata),
      .debug_cnt(debug_cnt), .fir(fir), .result_valid(sh_valid),
      .result_failed(sh_failed), .result_data(sh_data), .cmd_strobe(cmd_strobe),
      .debug_cnt_clear(debug_cnt_clear), .tlx_idle_lim(tlx_idle_lim),
      .axi_idle_lim(axi_idle_lim));

   soft_reset_gen #(.SOFT_RESET_CYCLES(SOFT_RESET_CYCLES)) u_soft_reset (
      .clk(clk), .rst_n(rst_n), .cmd_strobe(cmd_strobe),
      .soft_reset_shell(soft_reset_shell), .soft_reset_action(soft_reset_action));

   action_bridge u_bridge (
      .clk(clk), .rst_n(rst_n), .action_start(action_start), .mmio_req(mmio_req),
      .lcl_req(lcl_req), .lcl_rsp(lcl_rsp), .result_valid(br_valid),
      .result_failed(br_failed), .result_data(br_data));

   // Only one source answers per request, so OR-merge is enough
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rsp_done   <= 1'b0;
         rsp_failed <= 1'b0;
      end
      else
      begin
         rsp_done   <= sh_valid || br_valid;
         rsp_failed <= sh_failed || br_failed;
      end
   end

   always_ff @(posedge clk)
      rsp_dout <= ({64{sh_valid}} & sh_data) | ({64{br_valid}} & br_data);

   assign mmio_rsp = '{dout: rsp_dout, done: rsp_done, failed: rsp_failed};

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
/*
 * Clock source for the MMIO testbench, 4 ns period.
 * Instance it once in the testbench top and take clk from it.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;                           // 2 ns half period
   end

endmodule

`default_nettype wire

//--- tb/mmio_sva.sv
/*
 * Protocol assertions for the MMIO block, bound to every mmio_top.
 * Covers the host response, action strobes and soft-reset length.
 */
`timescale 1ns/10ps
`default_nettype none

module mmio_sva #(
   parameter int SOFT_RESET_CYCLES = 16
) (
   input wire logic                clk,
   input wire logic                rst_n,
   input wire mmio_pkg::mmio_rsp_t mmio_rsp,
   input wire mmio_pkg::lcl_req_t  lcl_req,
   input wire logic                soft_reset_shell
);

   // Response is either done or failed, never both
   a_rsp_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      !(mmio_rsp.done && mmio_rsp.failed))
      else $error("done and failed high in the same cycle");

   a_strobe_len: assert property (@(posedge clk) disable iff (!rst_n)
      (lcl_req.wr || lcl_req.rd) |=> !(lcl_req.wr || lcl_req.rd))
      else $error("lcl_req strobe longer than one cycle");

   // Pulse of exactly SOFT_RESET_CYCLES, then low
   a_pulse_len: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(soft_reset_shell) |-> soft_reset_shell [*SOFT_RESET_CYCLES] ##1 !soft_reset_shell)
      else $error("soft reset pulse has wrong length");

endmodule

bind mmio_top mmio_sva #(.SOFT_RESET_CYCLES(SOFT_RESET_CYCLES)) u_sva (
   .clk(clk), .rst_n(rst_n), .mmio_rsp(mmio_rsp), .lcl_req(lcl_req),
   .soft_reset_shell(soft_reset_shell));

`default_nettype wire

//--- tb/mmio_tb.sv
/*
 * Testbench for mmio_top. Reads tb/mmio_stim.txt line by line, drives host
 * accesses, models the action register bus and checks every response.
 */
`timescale 1ns/10ps
`default_nettype none

module mmio_tb;

   localparam logic [63:0] IMP_VERSION = 64'h1122_3344_5566_7788;
   localparam logic [63:0] CAPABILITY  = 64'h0000_0000_0000_0A5C;
   localparam int SOFT_RESET_CYCLES = 16;
   localparam int TIMEOUT           = 40;       // Cycles per wait loop

   logic                 clk;
   logic                 rst_n;
   mmio_pkg::mmio_req_t  mmio_req;
   mmio_pkg::mmio_rsp_t  mmio_rsp;
   mmio_pkg::lcl_req_t   lcl_req;
   mmio_pkg::lcl_rsp_t   lcl_rsp;
   mmio_pkg::debug_cnt_t debug_cnt;
   mmio_pkg::fir_t       fir;
   logic                 debug_cnt_clear, soft_reset_shell, soft_reset_action;
   logic [63:0]          tlx_idle_lim, axi_idle_lim;
   logic [63:0]          last_rd;                 // Previous read data, for FRT
   logic [31:0]          act_mem [0:15];          // Action register space
   logic [31:0]          act_addr, act_din;
   logic                 act_wr;
   int                   act_wait;
   integer               seed;

   tb_clk_gen u_clk (.clk(clk));

   mmio_top #(.IMP_VERSION(IMP_VERSION), .CAPABILITY(CAPABILITY),
              .SOFT_RESET_CYCLES(SOFT_RESET_CYCLES)) uut (
      .clk(clk), .rst_n(rst_n), .mmio_req(mmio_req), .mmio_rsp(mmio_rsp),
      .lcl_req(lcl_req), .lcl_rsp(lcl_rsp), .debug_cnt(debug_cnt), .fir(fir),
      .debug_cnt_clear(debug_cnt_clear), .soft_reset_shell(soft_reset_shell),
      .soft_reset_action(soft_reset_action), .tlx_idle_lim(tlx_idle_lim),
      .axi_idle_lim(axi_idle_lim));

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic step;                            // Next edge plus drive delay
      @(posedge clk);
      #1;
   endtask

   // ========================================================================
   // Action model, answers 1 to 6 cycles after the strobe
   // ========================================================================
   initial
   begin
      seed     = 16;
      act_wait = 0;
      lcl_rsp  = '0;
      for (int i = 0; i < 16; i++)
         act_mem[i] = 32'h0;
      forever
      begin
         step();
         lcl_rsp.ack = 1'b0;
         lcl_rsp.dv  = 1'b0;
         if (act_wait > 0)
         begin
            act_wait = act_wait - 1;
            if (act_wait == 0)
            begin
               lcl_rsp.rsp = !act_addr[20];           // Bit 20 set answers bad
               lcl_rsp.ack = act_wr;
               lcl_rsp.dv  = !act_wr;
               lcl_rsp.dout = act_mem[act_addr[5:2]];
               if (act_wr && !act_addr[20])
                  act_mem[act_addr[5:2]] = act_din;
            end
         end
         else if (lcl_req.wr || lcl_req.rd)
         begin
            act_addr = lcl_req.addr;
            act_din  = lcl_req.din;
            act_wr   = lcl_req.wr;
            act_wait = 1 + ($unsigned($random(seed)) % 6);
         end
      end
   end

   // ========================================================================
   // Host access with all response checks
   // ========================================================================
   task automatic access_host(input logic wr, input logic [31:0] addr, input logic dw,
                              input logic [63:0] data, input logic [63:0] exp,
                              input int outc, input string tname);
      int          cyc;
      int          strobes;
      int          len;
      logic        act_ok;
      logic        rsp_seen;
      logic [31:0] half;
      act_ok   = addr[31] && !dw;                  // Valid action access
      half     = addr[2] ? data[63:32] : data[31:0];
      cyc      = 0;
      strobes  = 0;
      rsp_seen = 1'b0;
      mmio_req = '{wr: wr, rd: !wr, dw: dw, addr: addr, din: data};
      while (!rsp_seen && cyc < TIMEOUT)
      begin
         step();
         cyc++;
         mmio_req.wr = 1'b0;
         mmio_req.rd = 1'b0;
         if (lcl_req.wr || lcl_req.rd)
         begin
            strobes++;
            assert (act_ok && cyc == 1 && lcl_req.wr == wr)
            else abort_run($sformatf("unexpected lcl_req strobe in %s", tname));
            assert (lcl_req.addr == {1'b0, addr[30:0]})
            else abort_run($sformatf("MISMATCH %s lcl addr: expected %h, actual %h",
                                     tname, {1'b0, addr[30:0]}, lcl_req.addr));
            assert (!wr || lcl_req.din == half)
            else abort_run($sformatf("MISMATCH %s lcl din: expected %h, actual %h",
                                     tname, half, lcl_req.din));
         end
         assert (debug_cnt_clear == (wr && outc == 3 && cyc == 2))
         else abort_run($sformatf("MISMATCH %s debug_cnt_clear: expected %b, actual %b",
                                  tname, (wr && outc == 3 && cyc == 2), debug_cnt_clear));
         rsp_seen = mmio_rsp.done || mmio_rsp.failed;
      end
      if (!rsp_seen)
         abort_run($sformatf("no done or failed response for %s", tname));
      assert (strobes == (act_ok ? 1 : 0))
      else abort_run($sformatf("wrong number of lcl_req strobes in %s", tname));
      assert (act_ok || cyc == 2)
      else abort_run($sformatf("MISMATCH %s latency: expected 2, actual %0d", tname, cyc));
      assert (mmio_rsp.failed == (outc == 1))
      else abort_run($sformatf("MISMATCH %s failed: expected %b, actual %b",
                               tname, (outc == 1), mmio_rsp.failed));
      assert (wr || outc != 0 || mmio_rsp.dout == exp)
      else abort_run($sformatf("MISMATCH %s: expected %h, actual %h", tname, exp, mmio_rsp.dout));
      if (!wr && outc == 0 && addr == 32'h0001_A068)
         check_limit(1'b1, exp, tname);            // AXI limit port matches its register
      assert (wr || outc != 2 || mmio_rsp.dout > last_rd)
      else abort_run($sformatf("MISMATCH %s FRT: expected above %h, actual %h",
                               tname, last_rd, mmio_rsp.dout));
      if (!wr)
         last_rd = mmio_rsp.dout;
      step();                                      // C+3
      assert (!debug_cnt_clear)
      else abort_run($sformatf("debug_cnt_clear still high after %s", tname));
      assert (soft_reset_shell == (wr && outc == 2) && soft_reset_action == soft_reset_shell)
      else abort_run($sformatf("soft reset outputs wrong in C+3 of %s", tname));
      len = 0;
      while (soft_reset_shell && len < TIMEOUT)  // Measure the pulse
      begin
         assert (soft_reset_action)
         else abort_run($sformatf("soft_reset_action dropped early in %s", tname));
         len++;
         step();
      end
      assert (!(wr && outc == 2) || len == SOFT_RESET_CYCLES)
      else abort_run($sformatf("MISMATCH %s pulse: expected %0d, actual %0d",
                               tname, SOFT_RESET_CYCLES, len));
   endtask

   task automatic apply_input(input logic [2:0] field, input logic [63:0] value);
      case (field)
         3'd0:    debug_cnt.tlx_cmd = value;
         3'd1:    debug_cnt.tlx_rsp = value;
         3'd2:    debug_cnt.axi_cmd = value;
         3'd3:    debug_cnt.axi_rsp = value;
         3'd4:    debug_cnt.buf_cnt = value;
         3'd5:    fir.fifo_ovfl     = value;
         default: fir.tlx_intf      = value;
      endcase
      step();
   endtask

   task automatic check_limit(input logic sel, input logic [63:0] exp, input string tname);
      logic [63:0] act;
      act = sel ? axi_idle_lim : tlx_idle_lim;
      assert (act == exp)
      else abort_run($sformatf("MISMATCH %s: expected %h, actual %h", tname, exp, act));
   endtask

   // ========================================================================
   // Main sequence
   // ========================================================================
   initial
   begin
      int               fd;
      int               n;
      int               count;
      int               op, dw, outc;
      logic [31:0]      addr;
      logic [63:0]      data, exp;
      logic [8*160-1:0] line;
      string            tname;
      mmio_req  = '0;
      debug_cnt = '0;
      fir       = '0;
      last_rd   = '0;
      rst_n     = 1'b0;
      count     = 0;
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
      step();
      assert (!mmio_rsp.done && !mmio_rsp.failed && !lcl_req.wr && !lcl_req.rd &&
              !debug_cnt_clear && !soft_reset_shell && !soft_reset_action)
      else abort_run("control outputs not low after reset");
      fd = $fopen("tb/mmio_stim.txt", "r");
      if (fd == 0)
         abort_run("cannot open stimulus file tb/mmio_stim.txt");
      while (!$feof(fd))
      begin
         line = '0;
         n    = $fgets(line, fd);
         n    = $sscanf(line, "%h %h %h %h %h %h %s", op, addr, dw, data, exp, outc, tname);
         if (n == 7)                               // Comments and blanks skipped
         begin
            count++;
            case (op)
               0:       access_host(1'b1, addr, dw[0], data, exp, outc, tname);
               1:       access_host(1'b0, addr, dw[0], data, exp, outc, tname);
               2:       apply_input(addr[2:0], data);
               default: check_limit(addr[0], exp, tname);
            endcase
         end
      end
      $fclose(fd);
      if (count == 0)
         abort_run("stimulus file held no transactions");
      else
      begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- tb/mmio_stim.txt
# op addr dw data expected outcome name   (all numbers hex)
# op 0 write, 1 read, 2 set input (addr 0-6 picks field), 3 check idle limit (addr 0 tlx, 1 axi)
# outcome 0 done, 1 failed, 2 soft reset pulse or rising FRT, 3 debug clear pulse
0 0001A060 1 00000000CAFE0001 0 0 wr_tlx_lim
0 0001A068 1 1234567800000ABC 0 0 wr_axi_lim
1 0001A060 1 0 00000000CAFE0001 0 rd_tlx_lim
1 0001A068 1 0 1234567800000ABC 0 rd_axi_lim
3 00000000 0 0 00000000CAFE0001 0 port_tlx_lim
1 00000000 1 0 1122334455667788 0 rd_ivr
1 00000030 1 0 0000000000000A5C 0 rd_cap
2 00000000 0 5 0 0 set_tlx_cmd
2 00000001 0 3 0 0 set_tlx_rsp
2 00000002 0 7 0 0 set_axi_cmd
2 00000003 0 7 0 0 set_axi_rsp
2 00000006 0 100 0 0 set_tlx_intf
1 0001A008 1 0 5 0 rd_tlx_cmd
1 0001C008 1 0 100 0 rd_tlx_intf
1 00000018 1 0 B 0 rd_ssr_idle_tlx_fatal
2 00000004 0 4 0 0 set_buf_cnt
2 00000001 0 5 0 0 set_tlx_rsp_eq
2 00000003 0 9 0 0 set_axi_rsp_ne
2 00000006 0 0 0 0 clr_tlx_intf
1 00000018 1 0 4 0 rd_ssr_axi_busy
1 0001A050 1 0 4 0 rd_buf_cnt
1 00000040 1 0 0 2 rd_frt_first
1 00000040 1 0 0 2 rd_frt_second
0 0001A060 0 FFFFFFFFFFFFFFFF 0 1 bad_width_shell_wr
0 80000000 1 DEADBEEFDEADBEEF 0 1 bad_width_action_wr
1 80000000 1 0 0 1 bad_width_action_rd
1 00000020 1 0 0 1 undef_offset
1 00000010 1 0 0 1 rd_scr
0 00000000 1 1 0 1 wr_ivr
1 0001A060 1 0 00000000CAFE0001 0 tlx_lim_kept
1 00000000 1 0 1122334455667788 0 ivr_kept
0 80000000 0 AAAAAAAA55555555 0 0 act_wr_lo
0 8000000C 0 13579BDF2468ACE0 0 0 act_wr_hi
1 80000000 0 0 0000000055555555 0 act_rd_lo
1 8000000C 0 0 13579BDF00000000 0 act_rd_hi
0 80100008 0 0000000012345678 0 1 act_wr_bad
1 80100008 0 0 0 1 act_rd_bad
0 00000010 1 1 0 2 soft_reset
0 0001A000 1 1 0 3 debug_clear

//--- files.f
src/mmio_pkg.sv
src/mmio_access_decode.sv
src/shell_regs.sv
src/soft_reset_gen.sv
src/action_bridge.sv
src/mmio_top.sv
tb/tb_clk_gen.sv
tb/mmio_sva.sv
tb/mmio_tb.sv

//--- Bender.yml
package:
  name: mmio_regs

sources:
  - src/mmio_pkg.sv
  - src/mmio_access_decode.sv
  - src/shell_regs.sv
  - src/soft_reset_gen.sv
  - src/action_bridge.sv
  - src/mmio_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/mmio_sva.sv
      - tb/mmio_tb.sv
